// File: hw/vmul_cfg_pkg.sv
// vector multiply configuration: vector width, slot and product sizes, element widths
package vmul_cfg_pkg;

   // vector register width in bits
   localparam int VLEN = 64;

   // each multiplier slot holds one element extended to 64 bits
   localparam int SLOT_W = 64;

   // one slot per byte lane, enough for the SEW8 case
   localparam int NUM_SLOTS = VLEN / 8;

   // full product of two 64-bit slots
   localparam int PROD_W = 128;

   // element width encoding, as in vsew
   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2,
      SEW64 = 2'd3
   } sew_t;

   // sized operands, slot k carries element k
   typedef logic [NUM_SLOTS-1:0][SLOT_W-1:0] slot_vec_t;

   // products, one per slot
   typedef logic [NUM_SLOTS-1:0][PROD_W-1:0] prod_vec_t;

endpackage

// File: hw/vmul_op_pkg.sv
// vector multiply operation encoding: kinds, fixed-point rounding modes, operation struct
package vmul_op_pkg;

   // what the unit computes from the product
   typedef enum logic [1:0] {
      MUL_LO = 2'd0,
      MUL_HI = 2'd1,
      VSMUL  = 2'd2,
      MACC   = 2'd3
   } op_kind_t;

   // fixed-point rounding mode, vxrm csr encoding
   typedef enum logic [1:0] {
      RNU = 2'd0,
      RNE = 2'd1,
      RDN = 2'd2,
      ROD = 2'd3
   } vxrm_t;

   // one operation as it travels down the pipe
   typedef struct packed {
      op_kind_t           kind;
      vmul_cfg_pkg::sew_t sew;
      vxrm_t              vxrm;
      // source 1 treated as signed
      logic               sgn1;
      // source 2 treated as signed
      logic               sgn2;
   } vmul_op_t;

endpackage

// File: hw/vmul_operand_sizer.sv
// operand sizer: moves each source element into its own 64-bit slot, sign or zero extended
`timescale 1ns/10ps

module vmul_operand_sizer (
   input  logic                          i_clk,
   input  logic [vmul_cfg_pkg::VLEN-1:0] i_src,
   input  vmul_cfg_pkg::sew_t            i_sew,
   input  logic                          i_sgn,
   output vmul_cfg_pkg::slot_vec_t       o_slots
);

   localparam int VLEN = vmul_cfg_pkg::VLEN;

   // unused slots stay zero so their products are zero too
   always_comb begin
      o_slots = '0;
      case (i_sew)
         vmul_cfg_pkg::SEW8: begin
            for (int k = 0; k < VLEN / 8; k++) begin
               o_slots[k] = {{56{i_sgn & i_src[k*8+7]}}, i_src[k*8 +: 8]};
            end
         end
         vmul_cfg_pkg::SEW16: begin
            for (int k = 0; k < VLEN / 16; k++) begin
               o_slots[k] = {{48{i_sgn & i_src[k*16+15]}}, i_src[k*16 +: 16]};
            end
         end
         vmul_cfg_pkg::SEW32: begin
            for (int k = 0; k < VLEN / 32; k++) begin
               o_slots[k] = {{32{i_sgn & i_src[k*32+31]}}, i_src[k*32 +: 32]};
            end
         end
         default: begin
            // full width element, the extension bit is added in the product array
            for (int k = 0; k < VLEN / 64; k++) begin
               o_slots[k] = i_src[k*64 +: 64];
            end
         end
      endcase
   end

   // an unknown element width would silently zero the slots
   a_sew_known: assert property (@(posedge i_clk) !$isunknown(i_sew))
      else $error("element width is unknown at the operand sizer");

endmodule

// File: hw/vmul_product_array.sv
// product array: one signed multiplier per slot, registered into stage 1 with sign flags
`timescale 1ns/10ps

module vmul_product_array (
   input  logic                                  i_clk,
   input  vmul_cfg_pkg::slot_vec_t               i_slots1,
   input  vmul_cfg_pkg::slot_vec_t               i_slots2,
   input  vmul_cfg_pkg::sew_t                    i_sew,
   input  logic                                  i_sgn1,
   input  logic                                  i_sgn2,
   output vmul_cfg_pkg::prod_vec_t               o_prod,
   output logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    o_both_neg
);

   localparam int NUM_SLOTS = vmul_cfg_pkg::NUM_SLOTS;
   localparam int SLOT_W    = vmul_cfg_pkg::SLOT_W;
   localparam int PROD_W    = vmul_cfg_pkg::PROD_W;

   logic signed [SLOT_W:0]     opa [NUM_SLOTS];
   logic signed [SLOT_W:0]     opb [NUM_SLOTS];
   logic signed [2*SLOT_W+1:0] full [NUM_SLOTS];
   logic [NUM_SLOTS-1:0]       both_neg;

   // 65-bit operands so an unsigned 64-bit element keeps its magnitude
   // narrower elements are already extended, so bit 63 is the right extension
   always_comb begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
         opa[k]  = {i_sgn1 & i_slots1[k][SLOT_W-1], i_slots1[k]};
         opb[k]  = {i_sgn2 & i_slots2[k][SLOT_W-1], i_slots2[k]};
         full[k] = opa[k] * opb[k];
      end
   end

   // top bit of each element, used later to catch min times min under vsmul
   always_comb begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
         both_neg[k] = i_slots1[k][(8 << i_sew) - 1] & i_slots2[k][(8 << i_sew) - 1];
      end
   end

   always_ff @(posedge i_clk) begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
         o_prod[k] <= full[k][PROD_W-1:0];
      end
      o_both_neg <= both_neg;
   end

endmodule

// File: hw/vmul_result_select.sv
// result select: takes the wanted field of each product and its rounding bits into stage 2
`timescale 1ns/10ps

module vmul_result_select (
   input  logic                               i_clk,
   input  vmul_cfg_pkg::prod_vec_t            i_prod,
   input  logic [vmul_cfg_pkg::NUM_SLOTS-1:0] i_both_neg,
   input  vmul_op_pkg::vmul_op_t              i_op,
   output logic [vmul_cfg_pkg::VLEN-1:0]      o_res,
   output logic [vmul_cfg_pkg::NUM_SLOTS-1:0] o_bit_d,
   output logic [vmul_cfg_pkg::NUM_SLOTS-1:0] o_bit_dm1,
   output logic [vmul_cfg_pkg::NUM_SLOTS-1:0] o_bits_dm2to0,
   output logic [vmul_cfg_pkg::NUM_SLOTS-1:0] o_sat_pos
);

   localparam int VLEN      = vmul_cfg_pkg::VLEN;
   localparam int NUM_SLOTS = vmul_cfg_pkg::NUM_SLOTS;

   // everything picked out of the products for one element width
   typedef struct packed {
      logic [VLEN-1:0]      res;
      logic [NUM_SLOTS-1:0] d;
      logic [NUM_SLOTS-1:0] dm1;
      logic [NUM_SLOTS-1:0] dm2to0;
      logic [NUM_SLOTS-1:0] sat_pos;
   } pick_t;

   pick_t sel;
   logic  is_vsmul;

   assign is_vsmul = i_op.kind == vmul_op_pkg::VSMUL;

   // one candidate per element width, the part-selects are fixed inside each
   for (genvar s = 0; s < 4; s++) begin : g_sew
      localparam int EW = 8 << s;
      localparam int NE = VLEN / EW;

      pick_t pick;

      always_comb begin
         pick = '0;
         for (int k = 0; k < NE; k++) begin
            case (i_op.kind)
               vmul_op_pkg::MUL_HI: pick.res[k*EW +: EW] = i_prod[k][2*EW-1 -: EW];
               // vsmul keeps the product shifted right by sew-1
               vmul_op_pkg::VSMUL:  pick.res[k*EW +: EW] = i_prod[k][2*EW-2 -: EW];
               default:             pick.res[k*EW +: EW] = i_prod[k][EW-1:0];
            endcase
            pick.d[k]      = i_prod[k][EW-1];
            pick.dm1[k]    = i_prod[k][EW-2];
            pick.dm2to0[k] = |i_prod[k][EW-3:0];
            // only min times min gives a positive product reaching bit 2*sew-2
            pick.sat_pos[k] = i_both_neg[k] & ~i_prod[k][2*EW-1] & i_prod[k][2*EW-2];
         end
      end
   end

   always_comb begin
      case (i_op.sew)
         vmul_cfg_pkg::SEW16: sel = g_sew[1].pick;
         vmul_cfg_pkg::SEW32: sel = g_sew[2].pick;
         vmul_cfg_pkg::SEW64: sel = g_sew[3].pick;
         default:             sel = g_sew[0].pick;
      endcase
   end

   always_ff @(posedge i_clk) begin
      o_res <= sel.res;
   end

   // rounding bits only move for vsmul
   always_ff @(posedge i_clk) begin
      if (is_vsmul) begin
         o_bit_d       <= sel.d;
         o_bit_dm1     <= sel.dm1;
         o_bits_dm2to0 <= sel.dm2to0;
         o_sat_pos     <= sel.sat_pos;
      end
   end

endmodule

// File: hw/vmul_round_acc.sv
// round and accumulate: adds the vsmul rounding increment or src3 per element, then saturates
`timescale 1ns/10ps

module vmul_round_acc (
   input  logic                               i_clk,
   input  logic [vmul_cfg_pkg::VLEN-1:0]      i_res,
   input  logic [vmul_cfg_pkg::NUM_SLOTS-1:0] i_bit_d,
   input  logic [vmul_cfg_pkg::NUM_SLOTS-1:0] i_bit_dm1,
   input  logic [vmul_cfg_pkg::NUM_SLOTS-1:0] i_bits_dm2to0,
   input  logic [vmul_cfg_pkg::NUM_SLOTS-1:0] i_sat_pos,
   input  logic [vmul_cfg_pkg::VLEN-1:0]      i_src3,
   input  vmul_op_pkg::vmul_op_t              i_op,
   output logic [vmul_cfg_pkg::VLEN-1:0]      o_data,
   output logic                               o_sat
);

   localparam int VLEN      = vmul_cfg_pkg::VLEN;
   localparam int NUM_SLOTS = vmul_cfg_pkg::NUM_SLOTS;
   localparam int NUM_BYTES = VLEN / 8;

   logic                 is_vsmul;
   logic                 is_macc;
   logic [NUM_SLOTS-1:0] inc;
   logic [NUM_SLOTS-1:0] sat_el;
   logic [VLEN-1:0]      addend;
   logic [VLEN-1:0]      sum;

   assign is_vsmul = i_op.kind == vmul_op_pkg::VSMUL;
   assign is_macc  = i_op.kind == vmul_op_pkg::MACC;

   // rounding increment per element from the shifted-out bits
   always_comb begin
      logic rnd;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         case (i_op.vxrm)
            vmul_op_pkg::RNU: rnd = i_bit_dm1[k];
            vmul_op_pkg::RNE: rnd = i_bit_dm1[k] & (i_bits_dm2to0[k] | i_bit_d[k]);
            vmul_op_pkg::RDN: rnd = 1'b0;
            default:          rnd = ~i_bit_d[k] & (i_bit_dm1[k] | i_bits_dm2to0[k]);
         endcase
         inc[k] = is_vsmul & rnd;
      end
   end

   assign addend = is_macc ? i_src3 : '0;

   // byte adders whose carry only ripples inside one element
   // the first byte of an element takes the rounding increment instead
   always_comb begin
      int unsigned mask;
      logic        carry;
      logic        carry_in;
      mask  = (1 << i_op.sew) - 1;
      carry = 1'b0;
      for (int b = 0; b < NUM_BYTES; b++) begin
         carry_in = ((b & mask) == 0) ? inc[b >> i_op.sew] : carry;
         {carry, sum[b*8 +: 8]} = {1'b0, i_res[b*8 +: 8]} + {1'b0, addend[b*8 +: 8]}
                                  + 9'(carry_in);
      end
   end

   // saturated element is forced to the largest positive value
   always_comb begin
      int unsigned mask;
      mask   = (1 << i_op.sew) - 1;
      sat_el = '0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         if (k < (NUM_SLOTS >> i_op.sew)) begin
            sat_el[k] = is_vsmul & i_sat_pos[k];
         end
      end
      o_data = sum;
      for (int b = 0; b < NUM_BYTES; b++) begin
         if (sat_el[b >> i_op.sew]) begin
            o_data[b*8 +: 8] = ((b & mask) == mask) ? 8'h7f : 8'hff;
         end
      end
   end

   assign o_sat = |sat_el;

   // a saturating min times min product has no bits below its result field
   a_sat_clean_round: assert property (
      @(posedge i_clk) o_sat |-> is_vsmul &&
         ((sat_el & (i_bit_d | i_bit_dm1 | i_bits_dm2to0)) == '0))
      else $error("saturation flag raised outside vsmul or on a non-minimum product");

endmodule

// File: hw/vmul_ctrl_pipe.sv
// control pipe: valid bit, operation and the macc source through both pipeline stages
`timescale 1ns/10ps

module vmul_ctrl_pipe (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_valid,
   input  vmul_op_pkg::vmul_op_t         i_op,
   input  logic [vmul_cfg_pkg::VLEN-1:0] i_src3,
   output vmul_op_pkg::vmul_op_t         o_op_1a,
   output vmul_op_pkg::vmul_op_t         o_op_2a,
   output logic [vmul_cfg_pkg::VLEN-1:0] o_src3_2a,
   output logic                          o_valid_2a
);

   logic                          valid_1a;
   logic [vmul_cfg_pkg::VLEN-1:0] src3_1a;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         valid_1a   <= 1'b0;
         o_valid_2a <= 1'b0;
      end else begin
         valid_1a   <= i_valid;
         o_valid_2a <= valid_1a;
      end
   end

   always_ff @(posedge i_clk) begin
      o_op_1a <= i_op;
      o_op_2a <= o_op_1a;
   end

   // src3 only moves for macc
   always_ff @(posedge i_clk) begin
      if (i_valid && i_op.kind == vmul_op_pkg::MACC) begin
         src3_1a <= i_src3;
      end
      if (valid_1a && o_op_1a.kind == vmul_op_pkg::MACC) begin
         o_src3_2a <= src3_1a;
      end
   end

   // nothing accepted during reset may reach the output in the two cycles after
   a_no_valid_after_reset: assert property (
      @(posedge i_clk) i_reset |=> !o_valid_2a ##1 !o_valid_2a)
      else $error("output valid seen right after reset");

endmodule

// File: hw/vmul_top.sv
// vector integer multiply unit: two-stage pipeline for mul, mulh, vsmul and macc
`timescale 1ns/10ps

module vmul_top (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_valid,
   input  vmul_op_pkg::vmul_op_t         i_op,
   input  logic [vmul_cfg_pkg::VLEN-1:0] i_src1,
   input  logic [vmul_cfg_pkg::VLEN-1:0] i_src2,
   input  logic [vmul_cfg_pkg::VLEN-1:0] i_src3,
   output logic [vmul_cfg_pkg::VLEN-1:0] o_data,
   output logic                          o_valid,
   output logic                          o_sat
);

   vmul_cfg_pkg::slot_vec_t               slots1_0a;
   vmul_cfg_pkg::slot_vec_t               slots2_0a;
   vmul_cfg_pkg::prod_vec_t               prod_1a;
   logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    both_neg_1a;
   vmul_op_pkg::vmul_op_t                 op_1a;
   vmul_op_pkg::vmul_op_t                 op_2a;
   logic [vmul_cfg_pkg::VLEN-1:0]         src3_2a;
   logic [vmul_cfg_pkg::VLEN-1:0]         res_2a;
   logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    bit_d_2a;
   logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    bit_dm1_2a;
   logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    bits_dm2to0_2a;
   logic [vmul_cfg_pkg::NUM_SLOTS-1:0]    sat_pos_2a;

   vmul_operand_sizer i_sizer1 (
      .i_clk   (i_clk),
      .i_src   (i_src1),
      .i_sew   (i_op.sew),
      .i_sgn   (i_op.sgn1),
      .o_slots (slots1_0a)
   );

   vmul_operand_sizer i_sizer2 (
      .i_clk   (i_clk),
      .i_src   (i_src2),
      .i_sew   (i_op.sew),
      .i_sgn   (i_op.sgn2),
      .o_slots (slots2_0a)
   );

   vmul_product_array i_product_array (
      .i_clk      (i_clk),
      .i_slots1   (slots1_0a),
      .i_slots2   (slots2_0a),
      .i_sew      (i_op.sew),
      .i_sgn1     (i_op.sgn1),
      .i_sgn2     (i_op.sgn2),
      .o_prod     (prod_1a),
      .o_both_neg (both_neg_1a)
   );

   vmul_ctrl_pipe i_ctrl_pipe (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_valid    (i_valid),
      .i_op       (i_op),
      .i_src3     (i_src3),
      .o_op_1a    (op_1a),
      .o_op_2a    (op_2a),
      .o_src3_2a  (src3_2a),
      .o_valid_2a (o_valid)
   );

   vmul_result_select i_result_select (
      .i_clk         (i_clk),
      .i_prod        (prod_1a),
      .i_both_neg    (both_neg_1a),
      .i_op          (op_1a),
      .o_res         (res_2a),
      .o_bit_d       (bit_d_2a),
      .o_bit_dm1     (bit_dm1_2a),
      .o_bits_dm2to0 (bits_dm2to0_2a),
      .o_sat_pos     (sat_pos_2a)
   );

   vmul_round_acc i_round_acc (
      .i_clk         (i_clk),
      .i_res         (res_2a),
      .i_bit_d       (bit_d_2a),
      .i_bit_dm1     (bit_dm1_2a),
      .i_bits_dm2to0 (bits_dm2to0_2a),
      .i_sat_pos     (sat_pos_2a),
      .i_src3        (src3_2a),
      .i_op          (op_2a),
      .o_data        (o_data),
      .o_sat         (o_sat)
   );

endmodule

// File: test/tb_clkgen.sv
// clock source for the testbench, free running at a fixed period
`timescale 1ns/10ps

module tb_clkgen #(
   parameter int PERIOD_NS = 40
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

endmodule

// File: test/tb_vmul_top.sv
// testbench for the vector multiply unit that replays the pattern file and checks each result
`timescale 1ns/10ps

module tb_vmul_top;

   localparam int VLEN         = vmul_cfg_pkg::VLEN;
   localparam int NUM_VEC      = 22;
   localparam int RESET_CYCLES = 10;
   localparam int LATENCY      = 2;
   // reset, one vector per cycle, pipeline drain and some slack
   localparam int MAX_CYCLES   = RESET_CYCLES + NUM_VEC + LATENCY + 20;

   // one line of the pattern file
   typedef struct packed {
      vmul_op_pkg::vmul_op_t op;
      logic [VLEN-1:0]       src1;
      logic [VLEN-1:0]       src2;
      logic [VLEN-1:0]       src3;
      logic [VLEN-1:0]       data;
      logic [3:0]            sat;
   } pattern_t;

   // a result waiting for its output cycle
   typedef struct packed {
      logic [31:0]     idx;
      logic [31:0]     due;
      logic [VLEN-1:0] data;
      logic            sat;
   } pending_t;

   logic                        clk;
   logic                        rst;
   logic                        valid_in;
   vmul_op_pkg::vmul_op_t       op_in;
   logic [VLEN-1:0]             src1_in;
   logic [VLEN-1:0]             src2_in;
   logic [VLEN-1:0]             src3_in;
   logic [VLEN-1:0]             data_out;
   logic                        valid_out;
   logic                        sat_out;
   logic [$bits(pattern_t)-1:0] pattern_mem [NUM_VEC];
   pending_t                    exp_q [$];
   int                          cycle = 0;

   tb_clkgen #(.PERIOD_NS(40)) i_clkgen (.o_clk(clk));

   vmul_top i_vmul_top (
      .i_clk   (clk),
      .i_reset (rst),
      .i_valid (valid_in),
      .i_op    (op_in),
      .i_src1  (src1_in),
      .i_src2  (src2_in),
      .i_src3  (src3_in),
      .o_data  (data_out),
      .o_valid (valid_out),
      .o_sat   (sat_out)
   );

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "run stopped at cycle %0d", cycle);
   endtask

   // rising edges counted, the run is cut off past the limit
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   task automatic drive_vector(input int idx);
      pattern_t pat;
      pending_t pend;
      pat      = pattern_t'(pattern_mem[idx]);
      valid_in = 1'b1;
      op_in    = pat.op;
      src1_in  = pat.src1;
      src2_in  = pat.src2;
      src3_in  = pat.src3;
      // accepted on the next rising edge, seen two cycles after this one
      pend.idx  = idx;
      pend.due  = cycle + LATENCY;
      pend.data = pat.data;
      pend.sat  = pat.sat[0];
      exp_q.push_back(pend);
   endtask

   task automatic drive_idle();
      valid_in = 1'b0;
      op_in    = '0;
      src1_in  = '0;
      src2_in  = '0;
      src3_in  = '0;
   endtask

   task automatic check_outputs();
      pending_t pend;
      if (valid_out === 1'b1) begin
         assert (exp_q.size() != 0) else begin
            $display("output valid raised at cycle %0d with no result expected", cycle);
            abort_run();
         end
         pend = exp_q.pop_front();
         assert (cycle == pend.due) else begin
            $display("result of vector %0d arrived at cycle %0d instead of cycle %0d",
                     pend.idx, cycle, pend.due);
            abort_run();
         end
         assert (data_out === pend.data) else begin
            $display("ERR o_data vector %0d: got 0x%h, expected 0x%h",
                     pend.idx, data_out, pend.data);
            abort_run();
         end
         assert (sat_out === pend.sat) else begin
            $display("ERR o_sat vector %0d: got 0x%h, expected 0x%h",
                     pend.idx, sat_out, pend.sat);
            abort_run();
         end
      end else begin
         assert (valid_out === 1'b0) else begin
            $display("output valid is unknown at cycle %0d", cycle);
            abort_run();
         end
         if (exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle) else begin
               $display("no output valid for vector %0d at cycle %0d", exp_q[0].idx, cycle);
               abort_run();
            end
         end
      end
   endtask

   initial begin
      // valid held high through reset, nothing may come out of it
      rst      = 1'b1;
      valid_in = 1'b1;
      op_in    = '0;
      src1_in  = '0;
      src2_in  = '0;
      src3_in  = '0;
      $readmemh("test/vmul_patterns.hex", pattern_mem);
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         @(negedge clk);
         check_outputs();
      end
      rst = 1'b0;
      // back to back, one vector per cycle
      for (int i = 0; i < NUM_VEC; i++) begin
         drive_vector(i);
         @(negedge clk);
         check_outputs();
      end
      drive_idle();
      // last result plus a few cycles to catch a stray valid
      repeat (LATENCY + 2) begin
         @(negedge clk);
         check_outputs();
      end
      if (exp_q.size() != 0) begin
         $display("%0d results never appeared at the output", exp_q.size());
         abort_run();
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

// File: test/vmul_patterns.hex
// op_src1_src2_src3_expected-data_expected-sat, one vector per line
// op byte is {kind[1:0], sew[1:0], vxrm[1:0], sgn1, sgn2}
03_807FFF0210F003FE_807FFF8111F0FD05_0000000000000000_000101021000F7F6_0
12_010080001234FFFF_0101FFFF00100003_0000000000000000_010080002340FFFD_0
21_FFFFFFFE00010001_123456780000FFFF_0000000000000000_DB975310FFFFFFFF_0
33_FFFFFFFFFFFFFFFD_0000000100000001_0000000000000000_FFFFFFFCFFFFFFFD_0
43_807FFF0210F003FE_807FFF8111F0FD05_0000000000000000_403F00FF0101FFFF_0
40_807FFF0210F003FE_807FFF8111F0FD05_0000000000000000_403FFE0101E10204_0
42_807FFF0210F003FE_807FFF8111F0FD05_0000000000000000_C03FFF0101F102FF_0
51_123401008000FFFF_800001000002FFFF_0000000000000000_F6E600010001FFFF_0
63_80000000FFFFFFFF_8000000000000002_0000000000000000_40000000FFFFFFFF_0
70_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF_0000000000000000_FFFFFFFFFFFFFFFE_0
72_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF_0000000000000000_FFFFFFFFFFFFFFFF_0
83_05FDFF0201010301_074001403F414040_0000000000000000_00FF000100010201_0
87_05FDFF0201010301_074001403F414040_0000000000000000_00FE000100010200_0
8B_05FDFF0201010301_074001403F414040_0000000000000000_00FEFF0100000100_0
8F_05FDFF0201010301_074001403F414040_0000000000000000_01FFFF0101010101_0
93_40000001FFFF01FF_4000000140004000_0000000000000000_2000000000000100_0
83_0000000080808080_0000000080018180_0000000000000000_000000007FFF7F7F_1
BB_8000000000000000_8000000000000000_0000000000000000_7FFFFFFFFFFFFFFF_1
C0_11007F0300FF0010_1100020500FF000F_E000020100FF0020_0100001000000010_0
D0_01000000FFFF00FF_0100000000010001_1234000000030001_1234000000020100_0
E0_000000000000FFFF_0000000000010001_0000000000000002_0000000000000001_0
F0_FFFFFFFFFFFFFFFF_0000000000000002_0000000000000005_0000000000000003_0

// File: vlog.f
hw/vmul_cfg_pkg.sv
hw/vmul_op_pkg.sv
hw/vmul_operand_sizer.sv
hw/vmul_product_array.sv
hw/vmul_result_select.sv
hw/vmul_round_acc.sv
hw/vmul_ctrl_pipe.sv
hw/vmul_top.sv
test/tb_clkgen.sv
test/tb_vmul_top.sv

// File: Bender.yml
package:
  name: vmul

sources:
  - files:
      - hw/vmul_cfg_pkg.sv
      - hw/vmul_op_pkg.sv
      - hw/vmul_operand_sizer.sv
      - hw/vmul_product_array.sv
      - hw/vmul_result_select.sv
      - hw/vmul_round_acc.sv
      - hw/vmul_ctrl_pipe.sv
      - hw/vmul_top.sv
  - target: test
    files:
      - test/tb_clkgen.sv
      - test/tb_vmul_top.sv
